// ==== common/piarb_cfg.svh ====
`ifndef PIARB_CFG_SVH
`define PIARB_CFG_SVH

// ============================================================
// field widths of the hop stream and its metadata
// ============================================================

`define FID_NBITS 8          // flow id, also sets flow table depth
`define TID_NBITS 6          // topic id, also sets topic table depth
`define PU_ID_NBITS 3        // port id
`define HOP_INFO_NBITS 64    // beat data

// ============================================================
// table entry and metadata widths
// ============================================================

`define FLOW_PU_NBITS 16     // msb is the flow enable
`define SWITCH_TAG_NBITS 12
`define CTIME_NBITS 16       // creation time
`define RCI_NBITS 2

// statistics counters
`define CNT_NBITS 16

`endif

// ==== common/piarb_pkg.sv ====
`include "piarb_cfg.svh"

package piarb_pkg;

	// ============================================================
	// vector types for the fields that carry a meaning
	// ============================================================

	typedef logic [`FID_NBITS-1:0] fid_t;
	typedef logic [`TID_NBITS-1:0] tid_t;
	typedef logic [`PU_ID_NBITS-1:0] pu_id_t;
	typedef logic [`HOP_INFO_NBITS-1:0] hop_data_t;

	// flow payload, top bit enables the flow
	typedef logic [`FLOW_PU_NBITS-1:0] flow_pu_t;

	typedef logic [`SWITCH_TAG_NBITS-1:0] switch_tag_t;
	typedef logic [`CTIME_NBITS-1:0] ctime_t;
	typedef logic [`RCI_NBITS-1:0] rci_t;
	typedef logic [`CNT_NBITS-1:0] cnt_t;

	// ============================================================
	// encodings
	// ============================================================

	// packet type seen by the pu
	typedef enum logic [1:0] {
		PKT_PLAIN = 2'd0,
		PKT_TYPE1 = 2'd2
	} pkt_type_e;

	// ingress framing
	typedef enum logic {
		ING_IDLE,   // waiting for sop
		ING_IN_PKT  // between sop and eop
	} ingress_state_e;

endpackage

// ==== verilog/hop_ingress.sv ====
`timescale 1ns/1ps

module hop_ingress (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input piarb_pkg::pu_id_t in_port_id,
	input logic in_sop,
	input logic in_eop,
	input piarb_pkg::hop_data_t in_data,
	input piarb_pkg::fid_t in_fid,
	input piarb_pkg::tid_t in_tid,
	input logic in_fid_sel,
	input logic in_type1,
	input piarb_pkg::rci_t in_rci,
	input piarb_pkg::ctime_t in_ctime,
	output logic acc_valid,
	output piarb_pkg::pu_id_t acc_port_id,
	output logic acc_sop,
	output logic acc_eop,
	output piarb_pkg::hop_data_t acc_data,
	output piarb_pkg::fid_t acc_fid,
	output piarb_pkg::tid_t acc_tid,
	output logic acc_fid_sel,
	output logic acc_type1,
	output piarb_pkg::rci_t acc_rci,
	output piarb_pkg::ctime_t acc_ctime,
	output piarb_pkg::cnt_t frame_err_count
);

	piarb_pkg::ingress_state_e state;
	logic accept;
	logic frame_err;

	// sop only opens a packet from idle, any other beat must be inside one
	assign accept = in_valid & ((state == piarb_pkg::ING_IDLE) ? in_sop : ~in_sop);
	assign frame_err = in_valid & ~accept;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= piarb_pkg::ING_IDLE;
			acc_valid <= 1'b0;
			frame_err_count <= '0;
		end else begin
			acc_valid <= accept;
			if (frame_err)
				frame_err_count <= frame_err_count + 1'b1;
			if (accept && in_sop && !in_eop)
				state <= piarb_pkg::ING_IN_PKT;
			else if (accept && in_eop)
				state <= piarb_pkg::ING_IDLE;
		end
	end

	// beat payload follows the input every cycle
	always_ff @(posedge clk) begin
		acc_port_id <= in_port_id;
		acc_sop <= in_sop;
		acc_eop <= in_eop;
		acc_data <= in_data;
	end

	// metadata registers double as the sop latch
	always_ff @(posedge clk) begin
		if (accept && in_sop) begin
			acc_fid <= in_fid;
			acc_tid <= in_tid;
			acc_fid_sel <= in_fid_sel;
			acc_type1 <= in_type1;
			acc_rci <= in_rci;
			acc_ctime <= in_ctime;
		end
	end

endmodule

// ==== lookup/flow_table.sv ====
`timescale 1ns/1ps
`include "piarb_cfg.svh"

module flow_table (
	input logic clk,
	input logic wr,
	input piarb_pkg::fid_t waddr,
	input piarb_pkg::flow_pu_t wdata,
	input piarb_pkg::fid_t raddr,
	output piarb_pkg::flow_pu_t rdata
);

	localparam int DEPTH = 1 << `FID_NBITS;

	piarb_pkg::flow_pu_t mem [DEPTH];

	// all flows start disabled
	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= wdata;
	end

	// one cycle read, old data on a same cycle write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== lookup/topic_table.sv ====
`timescale 1ns/1ps
`include "piarb_cfg.svh"

module topic_table (
	input logic clk,
	input logic wr,
	input piarb_pkg::tid_t waddr,
	input piarb_pkg::switch_tag_t wdata,
	input logic rd,
	input piarb_pkg::tid_t raddr,
	output piarb_pkg::switch_tag_t rdata
);

	localparam int DEPTH = 1 << `TID_NBITS;

	piarb_pkg::switch_tag_t mem [DEPTH];
	piarb_pkg::tid_t raddr_q;
	logic rd_q;

	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	// ============================================================
	// host write port
	// ============================================================

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= wdata;
	end

	// ============================================================
	// two cycle read through address and output registers
	// ============================================================

	always_ff @(posedge clk) begin
		rd_q <= rd;
		if (rd)
			raddr_q <= raddr;
		if (rd_q)
			rdata <= mem[raddr_q];  // holds the last tag between reads
	end

endmodule

// ==== lookup/piarb_lookup.sv ====
`timescale 1ns/1ps

module piarb_lookup (
	input logic clk,
	input logic rst,
	input logic host_flow_wr,
	input piarb_pkg::fid_t host_flow_waddr,
	input piarb_pkg::flow_pu_t host_flow_wdata,
	input logic acc_valid,
	input piarb_pkg::pu_id_t acc_port_id,
	input logic acc_sop,
	input logic acc_eop,
	input piarb_pkg::hop_data_t acc_data,
	input piarb_pkg::fid_t acc_fid,
	input piarb_pkg::tid_t acc_tid,
	input logic acc_fid_sel,
	input logic acc_type1,
	input piarb_pkg::rci_t acc_rci,
	input piarb_pkg::ctime_t acc_ctime,
	input piarb_pkg::flow_pu_t flow_value_rdata,
	input piarb_pkg::switch_tag_t topic_value_rdata,
	output logic topic_value_rd,
	output piarb_pkg::tid_t topic_value_raddr,
	output logic flow_value_wr,
	output piarb_pkg::flow_pu_t flow_value_wdata,
	output piarb_pkg::fid_t flow_value_raddr,
	output piarb_pkg::fid_t flow_value_waddr,
	output logic lkp_valid,
	output piarb_pkg::pu_id_t lkp_pid,
	output piarb_pkg::hop_data_t lkp_data,
	output logic lkp_sop,
	output logic lkp_eop,
	output logic lkp_fid_sel,
	output piarb_pkg::pkt_type_e lkp_pkt_type,
	output piarb_pkg::rci_t lkp_rci,
	output piarb_pkg::ctime_t lkp_ctime,
	output piarb_pkg::switch_tag_t lkp_switch_tag,
	output piarb_pkg::flow_pu_t lkp_f_payload,
	output piarb_pkg::fid_t lkp_fid,
	output piarb_pkg::tid_t lkp_tid
);

	// ============================================================
	// beat delay line, three stages
	// ============================================================

	logic valid_d [1:3];
	piarb_pkg::pu_id_t pid_d [1:3];
	logic sop_d [1:3];
	logic eop_d [1:3];
	piarb_pkg::hop_data_t data_d [1:3];
	piarb_pkg::fid_t fid_d [1:3];
	piarb_pkg::tid_t tid_d [1:3];
	logic fid_sel_d [1:3];
	logic type1_d [1:3];
	piarb_pkg::rci_t rci_d [1:3];
	piarb_pkg::ctime_t ctime_d [1:3];

	piarb_pkg::flow_pu_t flow_rdata_d1; // lines flow data up with stage 3

	always_ff @(posedge clk) begin
		pid_d[1] <= acc_port_id;
		sop_d[1] <= acc_sop;
		eop_d[1] <= acc_eop;
		data_d[1] <= acc_data;
		fid_d[1] <= acc_fid;
		tid_d[1] <= acc_tid;
		fid_sel_d[1] <= acc_fid_sel;
		type1_d[1] <= acc_type1;
		rci_d[1] <= acc_rci;
		ctime_d[1] <= acc_ctime;
		for (int i = 2; i <= 3; i++) begin
			pid_d[i] <= pid_d[i-1];
			sop_d[i] <= sop_d[i-1];
			eop_d[i] <= eop_d[i-1];
			data_d[i] <= data_d[i-1];
			fid_d[i] <= fid_d[i-1];
			tid_d[i] <= tid_d[i-1];
			fid_sel_d[i] <= fid_sel_d[i-1];
			type1_d[i] <= type1_d[i-1];
			rci_d[i] <= rci_d[i-1];
			ctime_d[i] <= ctime_d[i-1];
		end
		flow_rdata_d1 <= flow_value_rdata;
	end

	// ============================================================
	// table access and control
	// ============================================================

	always_ff @(posedge clk) begin
		topic_value_raddr <= acc_tid;
		flow_value_raddr <= acc_fid;
		flow_value_waddr <= host_flow_waddr;  // host write goes out one cycle later
		flow_value_wdata <= host_flow_wdata;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			topic_value_rd <= 1'b0;
			flow_value_wr <= 1'b0;
			valid_d[1] <= 1'b0;
			valid_d[2] <= 1'b0;
			valid_d[3] <= 1'b0;
			lkp_valid <= 1'b0;
		end else begin
			topic_value_rd <= acc_valid;
			flow_value_wr <= host_flow_wr;
			valid_d[1] <= acc_valid;
			valid_d[2] <= valid_d[1];
			valid_d[3] <= valid_d[2];
			lkp_valid <= valid_d[3];
		end
	end

	// output register, metadata assembled from stage 3
	always_ff @(posedge clk) begin
		lkp_pid <= pid_d[3];
		lkp_data <= data_d[3];
		lkp_sop <= sop_d[3];
		lkp_eop <= eop_d[3];
		lkp_fid_sel <= fid_sel_d[3];
		lkp_pkt_type <= type1_d[3] ? piarb_pkg::PKT_TYPE1 : piarb_pkg::PKT_PLAIN;
		lkp_rci <= rci_d[3];
		lkp_ctime <= ctime_d[3];
		lkp_switch_tag <= topic_value_rdata;  // topic read lands right at stage 3
		lkp_f_payload <= flow_rdata_d1;
		lkp_fid <= fid_d[3];
		lkp_tid <= tid_d[3];
	end

endmodule

// ==== verilog/pu_egress.sv ====
`timescale 1ns/1ps
`include "piarb_cfg.svh"

module pu_egress (
	input logic clk,
	input logic rst,
	input logic lkp_valid,
	input piarb_pkg::pu_id_t lkp_pid,
	input piarb_pkg::hop_data_t lkp_data,
	input logic lkp_sop,
	input logic lkp_eop,
	input logic lkp_fid_sel,
	input piarb_pkg::pkt_type_e lkp_pkt_type,
	input piarb_pkg::rci_t lkp_rci,
	input piarb_pkg::ctime_t lkp_ctime,
	input piarb_pkg::switch_tag_t lkp_switch_tag,
	input piarb_pkg::flow_pu_t lkp_f_payload,
	input piarb_pkg::fid_t lkp_fid,
	input piarb_pkg::tid_t lkp_tid,
	output logic pu_valid,
	output piarb_pkg::pu_id_t pu_pid,
	output piarb_pkg::hop_data_t pu_data,
	output logic pu_sop,
	output logic pu_eop,
	output logic pu_fid_sel,
	output piarb_pkg::pkt_type_e pu_pkt_type,
	output piarb_pkg::rci_t pu_rci,
	output piarb_pkg::ctime_t pu_ctime,
	output piarb_pkg::switch_tag_t pu_switch_tag,
	output piarb_pkg::flow_pu_t pu_f_payload,
	output piarb_pkg::fid_t pu_fid,
	output piarb_pkg::tid_t pu_tid,
	output piarb_pkg::cnt_t drop_count
);

	logic flow_en;
	logic pass_q;    // decision of the open packet
	logic pass_now;

	assign flow_en = lkp_f_payload[`FLOW_PU_NBITS-1];
	assign pass_now = lkp_sop ? flow_en : pass_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pass_q <= 1'b0;
			pu_valid <= 1'b0;
			drop_count <= '0;
		end else begin
			pu_valid <= lkp_valid & pass_now;
			if (lkp_valid && lkp_sop) begin
				pass_q <= flow_en;
				if (!flow_en)
					drop_count <= drop_count + 1'b1;  // one count per packet
			end
		end
	end

	always_ff @(posedge clk) begin
		pu_pid <= lkp_pid;
		pu_data <= lkp_data;
		pu_sop <= lkp_sop & lkp_valid & pass_now;
		pu_eop <= lkp_eop & lkp_valid & pass_now;
		pu_fid_sel <= lkp_fid_sel;
		pu_pkt_type <= lkp_pkt_type;
		pu_rci <= lkp_rci;
		pu_ctime <= lkp_ctime;
		pu_switch_tag <= lkp_switch_tag;
		pu_f_payload <= lkp_f_payload;
		pu_fid <= lkp_fid;
		pu_tid <= lkp_tid;
	end

endmodule

// ==== verilog/piarb_top.sv ====
`timescale 1ns/1ps

module piarb_top (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input piarb_pkg::pu_id_t in_port_id,
	input logic in_sop,
	input logic in_eop,
	input piarb_pkg::hop_data_t in_data,
	input piarb_pkg::fid_t in_fid,
	input piarb_pkg::tid_t in_tid,
	input logic in_fid_sel,
	input logic in_type1,
	input piarb_pkg::rci_t in_rci,
	input piarb_pkg::ctime_t in_ctime,
	input logic flow_wr,
	input piarb_pkg::fid_t flow_waddr,
	input piarb_pkg::flow_pu_t flow_wdata,
	input logic topic_wr,
	input piarb_pkg::tid_t topic_waddr,
	input piarb_pkg::switch_tag_t topic_wdata,
	output logic pu_valid,
	output piarb_pkg::pu_id_t pu_pid,
	output piarb_pkg::hop_data_t pu_data,
	output logic pu_sop,
	output logic pu_eop,
	output logic pu_fid_sel,
	output piarb_pkg::pkt_type_e pu_pkt_type,
	output piarb_pkg::rci_t pu_rci,
	output piarb_pkg::ctime_t pu_ctime,
	output piarb_pkg::switch_tag_t pu_switch_tag,
	output piarb_pkg::flow_pu_t pu_f_payload,
	output piarb_pkg::fid_t pu_fid,
	output piarb_pkg::tid_t pu_tid,
	output piarb_pkg::cnt_t frame_err_count,
	output piarb_pkg::cnt_t drop_count
);

	// ============================================================
	// ingress to lookup
	// ============================================================

	logic acc_valid, acc_sop, acc_eop, acc_fid_sel, acc_type1;
	piarb_pkg::pu_id_t acc_port_id;
	piarb_pkg::hop_data_t acc_data;
	piarb_pkg::fid_t acc_fid;
	piarb_pkg::tid_t acc_tid;
	piarb_pkg::rci_t acc_rci;
	piarb_pkg::ctime_t acc_ctime;

	// lookup to tables
	logic topic_value_rd, flow_value_wr;
	piarb_pkg::tid_t topic_value_raddr;
	piarb_pkg::switch_tag_t topic_value_rdata;
	piarb_pkg::fid_t flow_value_raddr, flow_value_waddr;
	piarb_pkg::flow_pu_t flow_value_wdata, flow_value_rdata;

	// lookup to egress
	logic lkp_valid, lkp_sop, lkp_eop, lkp_fid_sel;
	piarb_pkg::pu_id_t lkp_pid;
	piarb_pkg::hop_data_t lkp_data;
	piarb_pkg::pkt_type_e lkp_pkt_type;
	piarb_pkg::rci_t lkp_rci;
	piarb_pkg::ctime_t lkp_ctime;
	piarb_pkg::switch_tag_t lkp_switch_tag;
	piarb_pkg::flow_pu_t lkp_f_payload;
	piarb_pkg::fid_t lkp_fid;
	piarb_pkg::tid_t lkp_tid;

	hop_ingress hop_ingress_inst (.*);

	piarb_lookup piarb_lookup_inst (
		.*,
		.host_flow_wr(flow_wr),
		.host_flow_waddr(flow_waddr),
		.host_flow_wdata(flow_wdata)
	);

	flow_table flow_table_inst (
		.clk(clk),
		.wr(flow_value_wr),
		.waddr(flow_value_waddr),
		.wdata(flow_value_wdata),
		.raddr(flow_value_raddr),
		.rdata(flow_value_rdata)
	);

	topic_table topic_table_inst (
		.clk(clk),
		.wr(topic_wr),          // host writes the topic table directly
		.waddr(topic_waddr),
		.wdata(topic_wdata),
		.rd(topic_value_rd),
		.raddr(topic_value_raddr),
		.rdata(topic_value_rdata)
	);

	pu_egress pu_egress_inst (.*);

endmodule

// ==== tb/piarb_checker.sv ====
`timescale 1ns/1ps

module piarb_checker (
	input logic clk,
	input logic rst,
	input logic pu_valid,
	input logic pu_sop,
	input logic pu_eop
);

	logic open_pkt;  // an output packet has started and not yet ended
	logic prop_failed = 1'b0;  // set by any failing property

	always_ff @(posedge clk) begin
		if (rst)
			open_pkt <= 1'b0;
		else if (pu_valid && pu_sop && !pu_eop)
			open_pkt <= 1'b1;
		else if (pu_valid && pu_eop)
			open_pkt <= 1'b0;
	end

	// ============================================================
	// reset and framing of the output stream
	// ============================================================

	// pu_sop settles one edge after pu_valid
	reset_quiet: assert property (@(posedge clk) (rst && $past(rst)) |=> (!pu_valid && !pu_sop))
		else begin
			prop_failed = 1'b1;
			$error("pu_valid or pu_sop high during reset");
		end

	flags_need_valid: assert property (@(posedge clk) disable iff (rst)
		(pu_sop || pu_eop) |-> pu_valid)
		else begin
			prop_failed = 1'b1;
			$error("pu_sop or pu_eop without pu_valid");
		end

	sop_outside_pkt: assert property (@(posedge clk) disable iff (rst)
		(pu_valid && pu_sop) |-> !open_pkt)
		else begin
			prop_failed = 1'b1;
			$error("pu_sop inside an open packet");
		end

	beat_inside_pkt: assert property (@(posedge clk) disable iff (rst)
		(pu_valid && !pu_sop) |-> open_pkt)  // covers eop as well
		else begin
			prop_failed = 1'b1;
			$error("beat without sop outside a packet");
		end

endmodule

bind piarb_top piarb_checker piarb_checker_inst (
	.clk(clk),
	.rst(rst),
	.pu_valid(pu_valid),
	.pu_sop(pu_sop),
	.pu_eop(pu_eop)
);

// ==== tb/piarb_tb.sv ====
`timescale 1ns/1ps

module piarb_tb;

	logic clk;
	logic rst;
	logic in_valid;
	piarb_pkg::pu_id_t in_port_id;
	logic in_sop;
	logic in_eop;
	piarb_pkg::hop_data_t in_data;
	piarb_pkg::fid_t in_fid;
	piarb_pkg::tid_t in_tid;
	logic in_fid_sel;
	logic in_type1;
	piarb_pkg::rci_t in_rci;
	piarb_pkg::ctime_t in_ctime;
	logic flow_wr;
	piarb_pkg::fid_t flow_waddr;
	piarb_pkg::flow_pu_t flow_wdata;
	logic topic_wr;
	piarb_pkg::tid_t topic_waddr;
	piarb_pkg::switch_tag_t topic_wdata;
	logic pu_valid;
	piarb_pkg::pu_id_t pu_pid;
	piarb_pkg::hop_data_t pu_data;
	logic pu_sop;
	logic pu_eop;
	logic pu_fid_sel;
	piarb_pkg::pkt_type_e pu_pkt_type;
	piarb_pkg::rci_t pu_rci;
	piarb_pkg::ctime_t pu_ctime;
	piarb_pkg::switch_tag_t pu_switch_tag;
	piarb_pkg::flow_pu_t pu_f_payload;
	piarb_pkg::fid_t pu_fid;
	piarb_pkg::tid_t pu_tid;
	piarb_pkg::cnt_t frame_err_count;
	piarb_pkg::cnt_t drop_count;

	// stim records kept as text and parsed where used
	string flow_q[$];
	string topic_q[$];
	string beat_q[$];
	string exp_q[$];
	string final_line;
	logic [31:0] rng_state;

	piarb_top piarb_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// error handling and compares
	// ============================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_mismatch(input string name, input string got, input string exp);
		abort_run($sformatf("mismatch at time %0t: %s is %s, expected %s", $time, name, got, exp));
	endtask

	task automatic compare_data(input string name, input piarb_pkg::hop_data_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_tag(input string name, input piarb_pkg::switch_tag_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_payload(input string name, input piarb_pkg::flow_pu_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_cnt(input string name, input piarb_pkg::cnt_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic compare_type(input string name, input piarb_pkg::pkt_type_e got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic compare_pid(input string name, input piarb_pkg::pu_id_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic compare_fid(input string name, input piarb_pkg::fid_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_tid(input string name, input piarb_pkg::tid_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_rci(input string name, input piarb_pkg::rci_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic compare_ctime(input string name, input piarb_pkg::ctime_t got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic compare_bit(input string name, input logic got, exp);
		if (got !== exp)
			report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	// ============================================================
	// stimulus
	// ============================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int next_gap();
		rng_state = xorshift32(rng_state);
		return int'(rng_state & 32'd3);  // 0 to 3 idle cycles
	endfunction

	task automatic load_stim();
		int fd;
		int n;
		string line;
		string kind;
		fd = $fopen("tb/piarb_stim.txt", "r");
		if (fd == 0)
			abort_run("cannot open tb/piarb_stim.txt");
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1) begin
				kind = line.substr(0, 0);
				case (kind)
					"F": flow_q.push_back(line);
					"T": topic_q.push_back(line);
					"B": beat_q.push_back(line);
					"E": exp_q.push_back(line);
					"C": final_line = line;
					"#": ;  // column notes
					default: abort_run({"unknown record in stim file: ", line});
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic write_tables();
		piarb_pkg::fid_t faddr;
		piarb_pkg::flow_pu_t fvalue;
		piarb_pkg::tid_t taddr;
		piarb_pkg::switch_tag_t tvalue;
		foreach (flow_q[i]) begin
			if ($sscanf(flow_q[i], "F %h %h", faddr, fvalue) != 2)
				abort_run({"bad flow write record: ", flow_q[i]});
			@(negedge clk);
			flow_wr = 1'b1;
			flow_waddr = faddr;
			flow_wdata = fvalue;
		end
		foreach (topic_q[i]) begin
			if ($sscanf(topic_q[i], "T %h %h", taddr, tvalue) != 2)
				abort_run({"bad topic write record: ", topic_q[i]});
			@(negedge clk);
			flow_wr = 1'b0;
			topic_wr = 1'b1;
			topic_waddr = taddr;
			topic_wdata = tvalue;
		end
		@(negedge clk);
		flow_wr = 1'b0;
		topic_wr = 1'b0;
	endtask

	task automatic drive_beats();
		logic gap;
		int n;
		foreach (beat_q[i]) begin
			n = $sscanf(beat_q[i], "B %h", gap);
			if (gap)
				repeat (next_gap()) begin
					@(negedge clk);
					in_valid = 1'b0;
				end
			@(negedge clk);
			n = $sscanf(beat_q[i], "B %h %h %h %h %h %h %h %h %h %h %h", gap, in_port_id,
				in_sop, in_eop, in_data, in_fid, in_tid, in_fid_sel, in_type1, in_rci, in_ctime);
			if (n != 11)
				abort_run({"bad beat record: ", beat_q[i]});
			in_valid = 1'b1;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// ============================================================
	// output checking
	// ============================================================

	task automatic check_beat();
		piarb_pkg::pu_id_t pid;
		logic sop;
		logic eop;
		logic fid_sel;
		logic [1:0] ptype;
		piarb_pkg::hop_data_t data;
		piarb_pkg::rci_t rci;
		piarb_pkg::ctime_t ctime;
		piarb_pkg::switch_tag_t tag;
		piarb_pkg::flow_pu_t payload;
		piarb_pkg::fid_t fid;
		piarb_pkg::tid_t tid;
		string line;
		if (exp_q.size() == 0)
			abort_run($sformatf("unexpected output beat at time %0t", $time));
		line = exp_q.pop_front();
		if ($sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h", pid, sop, eop, data,
			fid_sel, ptype, rci, ctime, tag, payload, fid, tid) != 12)
			abort_run({"bad expected beat record: ", line});
		compare_pid("pu_pid", pu_pid, pid);
		compare_bit("pu_sop", pu_sop, sop);
		compare_bit("pu_eop", pu_eop, eop);
		compare_data("pu_data", pu_data, data);
		compare_bit("pu_fid_sel", pu_fid_sel, fid_sel);
		compare_type("pu_pkt_type", pu_pkt_type, piarb_pkg::pkt_type_e'(ptype));
		compare_rci("pu_rci", pu_rci, rci);
		compare_ctime("pu_ctime", pu_ctime, ctime);
		compare_tag("pu_switch_tag", pu_switch_tag, tag);
		compare_payload("pu_f_payload", pu_f_payload, payload);
		compare_fid("pu_fid", pu_fid, fid);
		compare_tid("pu_tid", pu_tid, tid);
	endtask

	// outputs change on the rising edge and hold through the falling one
	always @(negedge clk) begin
		if (!rst && pu_valid)
			check_beat();
	end

	task automatic check_counters();
		piarb_pkg::cnt_t ferr;
		piarb_pkg::cnt_t drops;
		if ($sscanf(final_line, "C %h %h", ferr, drops) != 2)
			abort_run("missing or bad counter record in stim file");
		compare_cnt("frame_err_count", frame_err_count, ferr);
		compare_cnt("drop_count", drop_count, drops);
	endtask

	initial begin
		int cycles;
		rst = 1'b1;
		in_valid = 1'b0;
		in_port_id = '0;
		in_sop = 1'b0;
		in_eop = 1'b0;
		in_data = '0;
		in_fid = '0;
		in_tid = '0;
		in_fid_sel = 1'b0;
		in_type1 = 1'b0;
		in_rci = '0;
		in_ctime = '0;
		flow_wr = 1'b0;
		flow_waddr = '0;
		flow_wdata = '0;
		topic_wr = 1'b0;
		topic_waddr = '0;
		topic_wdata = '0;
		rng_state = 32'd14;
		load_stim();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		write_tables();
		repeat (4) @(negedge clk);
		drive_beats();
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
			abort_run($sformatf("timeout with %0d output beats still missing", exp_q.size()));
		repeat (8) @(negedge clk);  // trailing drops and stray beats reach the counters
		check_counters();
		if (piarb_top_inst.piarb_checker_inst.prop_failed) begin
			abort_run("an output protocol assertion failed during the run");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== tb/piarb_stim.txt ====
# F flow_addr payload | T topic_addr tag | B gap port sop eop data fid tid fid_sel type1 rci ctime
# E pid sop eop data fid_sel pkt_type rci ctime tag payload fid tid | C frame_errs drops
F 11 8abc
F 22 8123
F 33 0456
T 05 a5a
T 2a 3c3
B 1 1 1 0 a000000000000001 11 05 1 1 2 1234
B 0 1 0 0 a000000000000002 33 2a 0 0 0 ffff
B 0 1 0 1 a000000000000003 44 00 0 0 1 0000
B 1 2 0 1 5555555555555555 22 2a 0 0 3 9999
B 1 3 1 0 b000000000000001 22 2a 0 0 1 0042
B 0 3 1 0 b0000000000000ff 11 05 1 1 3 7777
B 0 3 0 1 b000000000000002 00 00 1 1 0 0000
B 1 4 1 0 c000000000000001 33 05 1 1 2 0101
B 0 4 0 1 c000000000000002 11 05 0 0 0 0000
B 1 5 1 1 d000000000000001 11 2a 0 0 3 beef
B 0 6 1 1 e000000000000001 44 05 1 0 1 0e0e
B 0 7 1 1 f000000000000001 22 05 1 1 0 0777
E 1 1 0 a000000000000001 1 2 2 1234 a5a 8abc 11 05
E 1 0 0 a000000000000002 1 2 2 1234 a5a 8abc 11 05
E 1 0 1 a000000000000003 1 2 2 1234 a5a 8abc 11 05
E 3 1 0 b000000000000001 0 0 1 0042 3c3 8123 22 2a
E 3 0 1 b000000000000002 0 0 1 0042 3c3 8123 22 2a
E 5 1 1 d000000000000001 0 0 3 beef 3c3 8abc 11 2a
E 7 1 1 f000000000000001 1 2 0 0777 a5a 8123 22 05
C 2 2

// ==== list.f ====
+incdir+common
common/piarb_pkg.sv
verilog/hop_ingress.sv
lookup/flow_table.sv
lookup/topic_table.sv
lookup/piarb_lookup.sv
verilog/pu_egress.sv
verilog/piarb_top.sv
tb/piarb_checker.sv
tb/piarb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module piarb_tb -o piarb_sim
out=$(./obj_dir/piarb_sim || true)
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
